/* src.f */
logic/core_pkg.sv
logic/core_pipe_if.sv
logic/core_decode.sv
logic/core_execute.sv
logic/core_result.sv
logic/core_top.sv
verif/core_props.sv
verif/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and decide on the log contents
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f src.f -o core_sim \
    && ./obj_dir/core_sim 2>&1 | tee sim.log \
    || { echo "Simulation build or run reported an error"; exit 1; }
grep -qx "Testbench passed" sim.log \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

/* verif/core_tb.sv */
// Testbench for the three-stage integer core. Applies a table of arithmetic
// instructions with random idle gaps and checks each retirement in order.

`timescale 1ns/1ps
`default_nettype none

module core_tb;

    logic                g_clk;
    logic                rst_n;
    logic                instr_valid;
    core_pkg::word_t     instr;
    logic                ret_valid;
    core_pkg::word_t     ret_instr;
    core_pkg::reg_addr_t ret_rd;
    core_pkg::word_t     ret_wdata;
    logic                ret_trap;

    core_pkg::word_t     tbl_instr[$];               // Instruction words
    core_pkg::reg_addr_t tbl_rd[$];                  // Expected ret_rd
    core_pkg::word_t     tbl_wdata[$];               // Expected ret_wdata
    logic                tbl_trap[$];
    logic                tbl_tight[$];               // No idle gap before this row
    int                  ret_count = 0;
    logic [15:0]         lfsr;
    logic [1:0]          gap;

    core_top u_dut (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ret_valid   (ret_valid),
        .ret_instr   (ret_instr),
        .ret_rd      (ret_rd),
        .ret_wdata   (ret_wdata),
        .ret_trap    (ret_trap)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;                  // 20 ns period
    end

    // ----------------------------------------------------------------------
    // Encoders, LFSR and compare tasks
    // ----------------------------------------------------------------------

    function automatic core_pkg::word_t op_imm(input logic [2:0] f3, input logic [11:0] imm,
                                               input core_pkg::reg_addr_t rs1,
                                               input core_pkg::reg_addr_t rd);
        return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic core_pkg::word_t op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                               input core_pkg::reg_addr_t rs2,
                                               input core_pkg::reg_addr_t rs1,
                                               input core_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
    function automatic logic [15:0] step_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic add_row(input core_pkg::word_t w, input core_pkg::reg_addr_t rd,
                           input core_pkg::word_t wdata, input logic trap, input logic tight);
        tbl_instr.push_back(w);
        tbl_rd.push_back(rd);
        tbl_wdata.push_back(wdata);
        tbl_trap.push_back(trap);
        tbl_tight.push_back(tight);
    endtask

    task automatic stop_on_failure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t got,
                             input core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("error: time %0t, %s = %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: time %0t, %s = %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // Instruction table, expected values from all-zero registers
    // ----------------------------------------------------------------------

    task automatic fill_table();
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'hFFB, 5'd0, 5'd1),
                5'd1, 32'hFFFF_FFFB, 1'b0, 1'b0);            // ADDI x1 = -5
        add_row(op_imm(core_pkg::F3_SLT, 12'hFFC, 5'd1, 5'd2),
                5'd2, 32'h0000_0001, 1'b0, 1'b1);            // -5 < -4, forwarded
        add_row(op_imm(core_pkg::F3_SLTU, 12'hFFC, 5'd1, 5'd3),
                5'd3, 32'h0000_0001, 1'b0, 1'b1);            // Write-through of x1
        add_row(op_imm(core_pkg::F3_XOR, 12'hFFF, 5'd1, 5'd4),
                5'd4, 32'h0000_0004, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_OR, 12'hFF0, 5'd4, 5'd5),
                5'd5, 32'hFFFF_FFF4, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_AND, 12'hF00, 5'd5, 5'd6),
                5'd6, 32'hFFFF_FF00, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_SLL, 12'h004, 5'd1, 5'd7),
                5'd7, 32'hFFFF_FFB0, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_SR, 12'h01C, 5'd1, 5'd8),
                5'd8, 32'h0000_000F, 1'b0, 1'b0);            // SRLI by 28
        add_row(op_imm(core_pkg::F3_SR, 12'h401, 5'd1, 5'd9),
                5'd9, 32'hFFFF_FFFD, 1'b0, 1'b0);            // SRAI by 1
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'h123, 5'd0, 5'd10),
                5'd10, 32'h0000_0123, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'h007, 5'd0, 5'd11),
                5'd11, 32'h0000_0007, 1'b0, 1'b1);
        add_row(op_reg(7'h00, core_pkg::F3_ADD_SUB, 5'd11, 5'd10, 5'd12),
                5'd12, 32'h0000_012A, 1'b0, 1'b1);           // Both bypass paths
        add_row(op_reg(7'h20, core_pkg::F3_ADD_SUB, 5'd10, 5'd11, 5'd13),
                5'd13, 32'hFFFF_FEE4, 1'b0, 1'b0);           // SUB
        add_row(op_reg(7'h00, core_pkg::F3_AND, 5'd10, 5'd1, 5'd14),
                5'd14, 32'h0000_0123, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_OR, 5'd11, 5'd4, 5'd15),
                5'd15, 32'h0000_0007, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_XOR, 5'd10, 5'd1, 5'd16),
                5'd16, 32'hFFFF_FED8, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_SLT, 5'd11, 5'd1, 5'd17),
                5'd17, 32'h0000_0001, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_SLTU, 5'd11, 5'd1, 5'd18),
                5'd18, 32'h0000_0000, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_SLL, 5'd11, 5'd11, 5'd19),
                5'd19, 32'h0000_0380, 1'b0, 1'b0);
        add_row(op_reg(7'h00, core_pkg::F3_SR, 5'd11, 5'd1, 5'd20),
                5'd20, 32'h01FF_FFFF, 1'b0, 1'b0);           // SRL
        add_row(op_reg(7'h20, core_pkg::F3_SR, 5'd11, 5'd1, 5'd21),
                5'd21, 32'hFFFF_FFFF, 1'b0, 1'b0);           // SRA
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'd100, 5'd0, 5'd22),
                5'd22, 32'd100, 1'b0, 1'b0);
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'd1, 5'd22, 5'd23),
                5'd23, 32'd101, 1'b0, 1'b1);
        add_row(op_reg(7'h00, core_pkg::F3_ADD_SUB, 5'd23, 5'd22, 5'd24),
                5'd24, 32'd201, 1'b0, 1'b1);
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'd55, 5'd0, 5'd0),
                5'd0, 32'd55, 1'b0, 1'b0);                   // Write to x0
        add_row(op_reg(7'h00, core_pkg::F3_ADD_SUB, 5'd11, 5'd0, 5'd25),
                5'd25, 32'h0000_0007, 1'b0, 1'b1);           // x0 still zero
        add_row({12'h055, 5'd0, 3'b010, 5'd11, 7'b0000011},
                5'd0, 32'h0000_0000, 1'b1, 1'b0);            // Load opcode traps
        add_row(op_reg(7'h01, core_pkg::F3_ADD_SUB, 5'd10, 5'd11, 5'd10),
                5'd0, 32'h0000_0000, 1'b1, 1'b1);            // Bad funct7
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'h000, 5'd11, 5'd26),
                5'd26, 32'h0000_0007, 1'b0, 1'b1);           // x11 kept
        add_row(op_imm(core_pkg::F3_ADD_SUB, 12'h000, 5'd10, 5'd27),
                5'd27, 32'h0000_0123, 1'b0, 1'b1);           // x10 kept
    endtask

    // ----------------------------------------------------------------------
    // Stimulus, retirement monitor and watchdog
    // ----------------------------------------------------------------------

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 16'd7893;                      // Seed
        fill_table();
        repeat (3) @(posedge g_clk);
        rst_n <= 1'b1;
        for (int i = 0; i < tbl_instr.size(); i++) begin
            @(posedge g_clk);
            instr_valid <= 1'b1;
            instr       <= tbl_instr[i];
            lfsr = step_lfsr(lfsr);
            gap[0] = lfsr[0];
            lfsr = step_lfsr(lfsr);
            gap[1] = lfsr[0];
            if (i + 1 < tbl_instr.size() && tbl_tight[i + 1]) begin
                gap = 2'd0;                          // Back-to-back for bypass rows
            end
            for (int g = 0; g < int'(gap); g++) begin
                @(posedge g_clk);
                instr_valid <= 1'b0;
            end
        end
        @(posedge g_clk);
        instr_valid <= 1'b0;
        wait (ret_count == tbl_instr.size());
        repeat (4) @(posedge g_clk);                 // Catch stray retirements
        $display("Testbench passed");
        $finish;
    end

    // Outputs settle well before the falling edge
    always @(negedge g_clk) begin
        if (rst_n === 1'b1 && ret_valid === 1'b1) begin
            if (ret_count >= tbl_instr.size()) begin
                $display("An instruction retired that was never applied");
                stop_on_failure();
            end else begin
                check_word("ret_instr", ret_instr, tbl_instr[ret_count]);
                check_reg("ret_rd", ret_rd, tbl_rd[ret_count]);
                check_word("ret_wdata", ret_wdata, tbl_wdata[ret_count]);
                check_bit("ret_trap", ret_trap, tbl_trap[ret_count]);
                ret_count++;
            end
        end
    end

    initial begin
        @(posedge g_clk);                            // Table is filled by now
        repeat (tbl_instr.size() * 6 + 20) @(posedge g_clk);
        $display("Timeout: only %0d of %0d instructions retired, instructions were lost",
                 ret_count, tbl_instr.size());
        stop_on_failure();
    end

endmodule

`default_nettype wire

/* verif/core_props.sv */
// Assertions on the retirement outputs and register write enable of the
// result stage. Attached to every core_result instance by the bind below.

`timescale 1ns/1ps
`default_nettype none

module core_props (
    input logic            g_clk,
    input logic            rst_n,
    input logic            ret_valid,
    input logic            ret_trap,
    input core_pkg::word_t ret_instr,
    input logic            gpr_wen                   // Register file write this cycle
);

    logic opc_known;                                 // One of the two arithmetic groups
    logic f7_odd;                                    // OP funct7 beyond the ALT bit

    assign opc_known = (ret_instr[6:0] == core_pkg::OPC_OP) ||
                       (ret_instr[6:0] == core_pkg::OPC_OP_IMM);
    assign f7_odd    = (ret_instr[6:0] == core_pkg::OPC_OP) &&
                       ((ret_instr[31:25] & 7'b1011111) != '0);

    // Pipeline is empty when reset lets go
    ret_idle_after_reset: assert property (@(posedge g_clk) $rose(rst_n) |-> !ret_valid)
        else $error("ret_valid high in the first cycle after reset");

    // Encoding seen at retirement, not the trap flag carried from decode
    trap_no_write: assert property (@(posedge g_clk) disable iff (!rst_n)
        (ret_valid && (!opc_known || f7_odd)) |-> (ret_trap && !gpr_wen))
        else $error("Illegal instruction retired without trap or wrote the register file");

    ret_valid_known: assert property (@(posedge g_clk) disable iff (!rst_n)
        !$isunknown(ret_valid))
        else $error("ret_valid is unknown");

endmodule

bind core_result core_props u_props (
    .g_clk     (g_clk),
    .rst_n     (rst_n),
    .ret_valid (ret_valid),
    .ret_trap  (ret_trap),
    .ret_instr (ret_instr),
    .gpr_wen   (gpr_wen)
);

`default_nettype wire

/* logic/core_top.sv */
// Top level of the three-stage integer core. Instructions enter on a valid
// strobe and retire two cycles later on the ret_* outputs.

`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                g_clk,
    input  logic                rst_n,           // Sync, active low
    input  logic                instr_valid,     // Sample instr this edge
    input  core_pkg::word_t     instr,
    output logic                ret_valid,       // Retire strobe
    output core_pkg::word_t     ret_instr,
    output core_pkg::reg_addr_t ret_rd,          // Zero on trap
    output core_pkg::word_t     ret_wdata,       // Zero on trap
    output logic                ret_trap         // Illegal instruction
);

    // ----------------------------------------------------------------------
    // Stage buses
    // ----------------------------------------------------------------------

    gpr_rd_if gpr_bus ();                        // Decode reads register file
    issue_if  iss_bus ();                        // Decode to execute
    result_if res_bus ();                        // Execute to result

    core_decode u_decode (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .gpr         (gpr_bus.reader),
        .iss         (iss_bus.issue)
    );

    core_execute u_execute (
        .g_clk (g_clk),
        .rst_n (rst_n),
        .iss   (iss_bus.exec),
        .res   (res_bus.produce)
    );

    core_result u_result (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .res       (res_bus.retire),
        .gpr       (gpr_bus.file),
        .ret_valid (ret_valid),
        .ret_instr (ret_instr),
        .ret_rd    (ret_rd),
        .ret_wdata (ret_wdata),
        .ret_trap  (ret_trap)
    );

endmodule

`default_nettype wire

/* logic/core_result.sv */
// Result stage. Holds the 31 general registers, writes back at the end of
// the retire cycle and shows the retiring instruction on the ret_* outputs.

`timescale 1ns/1ps
`default_nettype none

module core_result (
    input  logic                g_clk,
    input  logic                rst_n,
    result_if.retire            res,
    gpr_rd_if.file              gpr,
    output logic                ret_valid,
    output core_pkg::word_t     ret_instr,
    output core_pkg::reg_addr_t ret_rd,
    output core_pkg::word_t     ret_wdata,
    output logic                ret_trap
);

    core_pkg::word_t regs [1:31];                    // x0 is not stored
    logic            gpr_wen;

    assign gpr_wen = res.valid && !res.trap && (res.rd != '0);

    // ----------------------------------------------------------------------
    // Register file
    // ----------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                       // Architectural state starts at zero
            end
        end else if (gpr_wen) begin
            regs[res.rd] <= res.wdata;
        end
    end

    // Write-through, so decode sees the instruction two places older
    assign gpr.rs1_data = (gpr.rs1_addr == '0)                   ? '0        :
                          (gpr_wen && (res.rd == gpr.rs1_addr))  ? res.wdata :
                                                                   regs[gpr.rs1_addr];
    assign gpr.rs2_data = (gpr.rs2_addr == '0)                   ? '0        :
                          (gpr_wen && (res.rd == gpr.rs2_addr))  ? res.wdata :
                                                                   regs[gpr.rs2_addr];

    // ----------------------------------------------------------------------
    // Retirement report
    // ----------------------------------------------------------------------

    assign ret_valid = res.valid;
    assign ret_instr = res.instr;
    assign ret_trap  = res.valid && res.trap;        // Only meaningful with valid
    assign ret_rd    = res.trap ? '0 : res.rd;       // Trap shows nothing written
    assign ret_wdata = res.trap ? '0 : res.wdata;    // x0 writes still show value

endmodule

`default_nettype wire

/* logic/core_execute.sv */
// Execute stage. Forwards the result of the instruction one place older,
// runs the ALU and registers the outcome for the result stage.

`timescale 1ns/1ps
`default_nettype none

module core_execute (
    input  logic        g_clk,
    input  logic        rst_n,
    issue_if.exec       iss,
    result_if.produce   res
);

    logic                              res_wr;       // Older instr will write rd
    logic                              fwd_rs1;
    logic                              fwd_rs2;
    core_pkg::word_t                   lhs;
    core_pkg::word_t                   rs2_val;
    core_pkg::word_t                   rhs;
    core_pkg::word_t                   alu_out;
    logic [core_pkg::SHAMT_W-1:0]      shamt;

    // ----------------------------------------------------------------------
    // Operand forwarding
    // ----------------------------------------------------------------------

    assign res_wr  = res.valid && !res.trap && (res.rd != '0);
    assign fwd_rs1 = res_wr && (res.rd == iss.rs1_addr);
    assign fwd_rs2 = res_wr && (res.rd == iss.rs2_addr);

    assign lhs     = fwd_rs1 ? res.wdata : iss.rs1_data;
    assign rs2_val = fwd_rs2 ? res.wdata : iss.rs2_data;
    assign rhs     = iss.use_imm ? iss.imm : rs2_val;     // I-type takes imm
    assign shamt   = rhs[core_pkg::SHAMT_W-1:0];

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------

    always_comb begin
        case (iss.op)
            core_pkg::ALU_ADD:  alu_out = lhs + rhs;
            core_pkg::ALU_SUB:  alu_out = lhs - rhs;
            core_pkg::ALU_SLL:  alu_out = lhs << shamt;
            core_pkg::ALU_SLT:  alu_out = core_pkg::word_t'($signed(lhs) < $signed(rhs));
            core_pkg::ALU_SLTU: alu_out = core_pkg::word_t'(lhs < rhs);
            core_pkg::ALU_XOR:  alu_out = lhs ^ rhs;
            core_pkg::ALU_SRL:  alu_out = lhs >> shamt;
            core_pkg::ALU_SRA:  alu_out = $unsigned($signed(lhs) >>> shamt); // Keep sign
            core_pkg::ALU_OR:   alu_out = lhs | rhs;
            core_pkg::ALU_AND:  alu_out = lhs & rhs;
            default:            alu_out = '0;        // Unused encodings
        endcase
    end

    // ----------------------------------------------------------------------
    // Result-stage register
    // ----------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= iss.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (iss.valid) begin
            res.wdata <= alu_out;
            res.rd    <= iss.rd;
            res.instr <= iss.instr;
            res.trap  <= iss.trap;                   // Blocks the write later
        end
    end

endmodule

`default_nettype wire

/* logic/core_decode.sv */
// Decode stage. Splits the instruction, reads the register file, builds the
// immediate and flags illegal encodings, then registers it all for execute.

`timescale 1ns/1ps
`default_nettype none

module core_decode (
    input  logic            g_clk,
    input  logic            rst_n,
    input  logic            instr_valid,             // One instruction per strobe
    input  core_pkg::word_t instr,
    gpr_rd_if.reader        gpr,
    issue_if.issue          iss
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [6:0]          f7_rest;                    // funct7 without the ALT bit
    logic                f7_alt;
    logic                is_op;
    logic                is_imm;
    logic                f7_bad;
    logic                trap;
    core_pkg::alu_op_e   op;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm;

    // ----------------------------------------------------------------------
    // Field extraction
    // ----------------------------------------------------------------------

    assign opcode  = instr[6:0];
    assign funct3  = instr[core_pkg::F3_LSB +: 3];
    assign funct7  = instr[core_pkg::F7_LSB +: 7];
    assign f7_alt  = instr[core_pkg::F7_ALT];
    assign f7_rest = funct7 & ~(7'b1 << (core_pkg::F7_ALT - core_pkg::F7_LSB));
    assign rd      = instr[core_pkg::RD_LSB +: core_pkg::REG_ADDR_W];

    assign gpr.rs1_addr = instr[core_pkg::RS1_LSB +: core_pkg::REG_ADDR_W];
    assign gpr.rs2_addr = instr[core_pkg::RS2_LSB +: core_pkg::REG_ADDR_W]; // Unused for I-type

    assign imm = {{(core_pkg::XLEN-12){instr[31]}}, instr[31:20]};   // I-type sign extend

    assign is_op  = (opcode == core_pkg::OPC_OP);
    assign is_imm = (opcode == core_pkg::OPC_OP_IMM);

    // ----------------------------------------------------------------------
    // Operation select and funct7 legality
    // ----------------------------------------------------------------------

    always_comb begin
        op     = core_pkg::ALU_ADD;
        f7_bad = 1'b0;
        case (funct3)
            core_pkg::F3_ADD_SUB: begin
                op     = (is_op && f7_alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD; // No SUBI
                f7_bad = is_op && (f7_rest != '0);
            end
            core_pkg::F3_SLL: begin
                op     = core_pkg::ALU_SLL;
                f7_bad = (funct7 != '0);             // Also imm[11:5] of SLLI
            end
            core_pkg::F3_SLT: begin
                op     = core_pkg::ALU_SLT;
                f7_bad = is_op && (funct7 != '0);
            end
            core_pkg::F3_SLTU: begin
                op     = core_pkg::ALU_SLTU;
                f7_bad = is_op && (funct7 != '0);
            end
            core_pkg::F3_XOR: begin
                op     = core_pkg::ALU_XOR;
                f7_bad = is_op && (funct7 != '0);
            end
            core_pkg::F3_SR: begin
                op     = f7_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                f7_bad = (f7_rest != '0);            // Both groups
            end
            core_pkg::F3_OR: begin
                op     = core_pkg::ALU_OR;
                f7_bad = is_op && (funct7 != '0);
            end
            core_pkg::F3_AND: begin
                op     = core_pkg::ALU_AND;
                f7_bad = is_op && (funct7 != '0);
            end
        endcase
    end

    assign trap = !(is_op || is_imm) || f7_bad;      // Anything else is illegal

    // ----------------------------------------------------------------------
    // Issue register
    // ----------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= instr_valid;                // One-cycle strobe
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid) begin
            iss.op       <= op;
            iss.rs1_addr <= gpr.rs1_addr;
            iss.rs2_addr <= gpr.rs2_addr;
            iss.rs1_data <= gpr.rs1_data;            // Includes write-through
            iss.rs2_data <= gpr.rs2_data;
            iss.use_imm  <= is_imm;
            iss.imm      <= imm;
            iss.rd       <= rd;
            iss.instr    <= instr;
            iss.trap     <= trap;
        end
    end

endmodule

`default_nettype wire

/* logic/core_pipe_if.sv */
// Stage-to-stage buses of the core: register read port, decode to execute
// and execute to result. No back-pressure on any of them.

`timescale 1ns/1ps
`default_nettype none

// Combinational register file read, two ports
interface gpr_rd_if;
    core_pkg::reg_addr_t rs1_addr;               // From decode
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;               // From the register file
    core_pkg::word_t     rs2_data;

    modport reader (output rs1_addr, rs2_addr, input  rs1_data, rs2_data);
    modport file   (input  rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// Decoded instruction, one-cycle valid strobe
interface issue_if;
    logic                valid;
    core_pkg::alu_op_e   op;
    core_pkg::reg_addr_t rs1_addr;               // Kept for forwarding compare
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;               // Read at decode, may be stale
    core_pkg::word_t     rs2_data;
    logic                use_imm;                // I-type, no rs2
    core_pkg::word_t     imm;                    // Sign-extended
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     instr;
    logic                trap;                   // Illegal encoding

    modport issue (output valid, op, rs1_addr, rs2_addr, rs1_data, rs2_data,
                   use_imm, imm, rd, instr, trap);
    modport exec  (input  valid, op, rs1_addr, rs2_addr, rs1_data, rs2_data,
                   use_imm, imm, rd, instr, trap);
endinterface

// Executed instruction waiting to retire
interface result_if;
    logic                valid;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     wdata;                  // ALU result
    core_pkg::word_t     instr;
    logic                trap;

    // Execute also reads these back for forwarding
    modport produce (output valid, rd, wdata, instr, trap);
    modport retire  (input  valid, rd, wdata, instr, trap);
endinterface

`default_nettype wire

/* logic/core_pkg.sv */
// Shared widths, instruction fields and ALU encodings for the three-stage core.
// Every design file refers to these by scoped name.

`default_nettype none

package core_pkg;

    // ----------------------------------------------------------------------
    // Widths and basic types
    // ----------------------------------------------------------------------

    localparam int XLEN       = 32;              // Data path width
    localparam int REG_ADDR_W = 5;               // x0..x31
    localparam int SHAMT_W    = 5;               // Shift amount bits used

    typedef logic [XLEN-1:0]       word_t;       // Register value or instruction
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;   // Register index

    // ----------------------------------------------------------------------
    // Instruction field positions
    // ----------------------------------------------------------------------

    localparam int RD_LSB  = 7;                  // rd field
    localparam int F3_LSB  = 12;                 // funct3 field
    localparam int RS1_LSB = 15;                 // rs1 field
    localparam int RS2_LSB = 20;                 // rs2 field, also I-imm low end
    localparam int F7_LSB  = 25;                 // funct7 field
    localparam int F7_ALT  = 30;                 // Selects SUB and SRA

    // Major opcodes of the two arithmetic groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;   // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // Register-immediate

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ----------------------------------------------------------------------
    // ALU operations
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,                                 // Signed compare
        ALU_SLTU,                                // Unsigned compare
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

`default_nettype wire
